/* raccoon_defines.svh */
`ifndef RACCOON_DEFINES_SVH
`define RACCOON_DEFINES_SVH

// Number of hardware threads in the barrel processor
`define RACCOON_THREADS 4

// Width of the node part of a ring packet ID
`define RACCOON_NODE_W 6

// Node number used when the top level is not given one
`define RACCOON_NODE_DEFAULT 6'd0

// Width of load/store data and of the address
`define RACCOON_DATA_W 32

`endif

/* raccoon_pkg.sv */
`include "raccoon_defines.svh"

package raccoon_pkg;

  // A thread number, also used for the issuing pipeline slice
  typedef logic [$clog2(`RACCOON_THREADS)-1:0] thread_id_t;

  // One ring packet, 79 bits, valid in the top bit
  typedef struct packed {
    logic                       valid;
    logic                       wr;
    logic                       ack;
    logic [`RACCOON_NODE_W-1:0] node;
    thread_id_t                 thread;
    logic [3:0]                 mask;
    logic [`RACCOON_DATA_W-1:0] data;
    logic [`RACCOON_DATA_W-1:0] addr;
  } racc_pkt_t;

  // Load or store request as issued by the pipeline
  typedef struct packed {
    logic                       wr;
    logic [`RACCOON_DATA_W-1:0] addr;
    logic [3:0]                 mask;
    logic [`RACCOON_DATA_W-1:0] wdata;
    logic [2:0]                 wb_reg;
  } lsu_req_t;

  // A thread slot holds exactly what the pipeline issued
  typedef lsu_req_t thread_slot_t;

  // Formatted load data going back to the register file
  typedef struct packed {
    thread_id_t                 slice;
    logic [2:0]                 sel;
    logic [`RACCOON_DATA_W-1:0] data;
  } load_result_t;

  // The slice that issues a memory op is two stages ahead of its thread
  function automatic thread_id_t thread_of_slice(thread_id_t slice);
    return slice + thread_id_t'(2);
  endfunction

endpackage

/* raccoon_req_decode.sv */
`include "raccoon_defines.svh"

module raccoon_req_decode
(
  input  logic                      CLK,
  input  logic                      RST,

  input  raccoon_pkg::thread_id_t   slice,
  input  logic                      req_valid,
  input  raccoon_pkg::lsu_req_t     req,

  input  logic [`RACCOON_THREADS-1:0] ack,

  output logic [`RACCOON_THREADS-1:0] pending,
  output raccoon_pkg::thread_slot_t slots [`RACCOON_THREADS]
);

  import raccoon_pkg::*;

  // One-hot request for the thread behind the issuing slice
  logic [`RACCOON_THREADS-1:0] req_hot;

  always_comb
  begin
    req_hot = '0;
    if (req_valid)
    begin
      req_hot[thread_of_slice(slice)] = 1'b1;
    end
  end

  // A thread stays pending from its request until the ring acknowledges it.
  // Retry leaves the bit alone, the thread simply waits longer
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      pending <= '0;
    end
    else
    begin
      pending <= (pending & ~ack) | req_hot;
    end
  end

  // Each thread keeps its own copy of the request so that it can be
  // sent again after a retry
  for (genvar t = 0; t < `RACCOON_THREADS; t++)
  begin : g_slot
    always_ff @(posedge CLK)
    begin
      if (req_hot[t])
      begin
        slots[t] <= req;
      end
    end
  end

  // The pipeline honours the stall outputs, so a thread never issues a
  // second request while its first one is still on the ring
  a_no_req_while_pending : assert property (
    @(posedge CLK) disable iff (RST)
    req_valid |-> !pending[thread_of_slice(slice)]
  );

  // An ack only arrives for a thread that has a transaction outstanding
  a_ack_only_when_pending : assert property (
    @(posedge CLK) disable iff (RST)
    (ack & ~pending) == '0
  );

endmodule

/* raccoon_bus_execute.sv */
`include "raccoon_defines.svh"

module raccoon_bus_execute
#(
  parameter logic [`RACCOON_NODE_W-1:0] NODE_ID = `RACCOON_NODE_DEFAULT
)
(
  input  logic                        CLK,
  input  logic                        RST,

  input  raccoon_pkg::racc_pkt_t      ring_in,
  output raccoon_pkg::racc_pkt_t      ring_out,

  input  logic [`RACCOON_THREADS-1:0] pending,
  input  raccoon_pkg::thread_slot_t   slots [`RACCOON_THREADS],

  output raccoon_pkg::racc_pkt_t      rx,
  output logic [`RACCOON_THREADS-1:0] ack,
  output logic [`RACCOON_THREADS-1:0] retry
);

  import raccoon_pkg::*;

  logic                        owned;
  logic                        forward;
  logic [`RACCOON_THREADS-1:0] owned_hot;

  thread_id_t                  turn;
  logic [`RACCOON_THREADS-1:0] sent;
  logic [`RACCOON_THREADS-1:0] sent_next;
  logic                        mark_vld;
  thread_id_t                  mark_thr;
  racc_pkt_t                   send_pkt;

  // Ring input is registered before anything looks at it
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      rx <= '0;
    end
    else
    begin
      rx <= ring_in;
    end
  end

  // A packet carrying our node number is a response to one of our threads.
  // Anything else that is valid belongs to another node and moves on
  assign owned   = rx.valid && (rx.node == NODE_ID);
  assign forward = rx.valid && (rx.node != NODE_ID);

  always_comb
  begin
    owned_hot = '0;
    if (owned)
    begin
      owned_hot[rx.thread] = 1'b1;
    end
  end

  assign ack   = rx.ack ? owned_hot : '0;
  assign retry = rx.ack ? '0 : owned_hot;

  // Request packet for the thread whose turn it is
  always_comb
  begin
    send_pkt        = '0;
    send_pkt.valid  = 1'b1;
    send_pkt.wr     = slots[turn].wr;
    send_pkt.ack    = 1'b0;
    send_pkt.node   = NODE_ID;
    send_pkt.thread = turn;
    send_pkt.mask   = slots[turn].mask;
    send_pkt.data   = slots[turn].wdata;
    send_pkt.addr   = slots[turn].addr;
  end

  // Forwarding wins over sending and holds the turn counter, which is the
  // only way the ring slows this node down
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      turn     <= '0;
      mark_vld <= 1'b0;
      mark_thr <= '0;
      ring_out <= '0;
    end
    else if (forward)
    begin
      mark_vld <= 1'b0;
      ring_out <= rx;
    end
    else
    begin
      turn <= turn + thread_id_t'(1);
      if (pending[turn] && !sent[turn])
      begin
        mark_vld <= 1'b1;
        mark_thr <= turn;
        ring_out <= send_pkt;
      end
      else
      begin
        mark_vld <= 1'b0;
        ring_out <= '0;
      end
    end
  end

  // Sent follows the mark by one cycle and drops on the response, so a
  // retried thread is picked up again on a later turn
  always_comb
  begin
    for (int t = 0; t < `RACCOON_THREADS; t++)
    begin
      sent_next[t] = (sent[t] || (mark_vld && (mark_thr == thread_id_t'(t))))
                     && !ack[t] && !retry[t];
    end
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      sent <= '0;
    end
    else
    begin
      sent <= sent_next;
    end
  end

  // A response only comes back for a packet this node has put on the ring
  a_resp_only_when_sent : assert property (
    @(posedge CLK) disable iff (RST)
    ((ack | retry) & ~sent) == '0
  );

endmodule

/* raccoon_load_result.sv */
`include "raccoon_defines.svh"

module raccoon_load_result
(
  input  logic                        CLK,
  input  logic                        RST,

  input  raccoon_pkg::racc_pkt_t      rx,
  input  logic [`RACCOON_THREADS-1:0] ack,
  input  raccoon_pkg::thread_slot_t   slots [`RACCOON_THREADS],

  output logic                        load_valid,
  output raccoon_pkg::load_result_t   load
);

  import raccoon_pkg::*;

  logic [3:0]                 resp_mask;
  logic [2:0]                 resp_reg;
  logic [`RACCOON_DATA_W-1:0] resp_data;

  // The response carries no mask or register, so take them from the slot
  assign resp_mask = slots[rx.thread].mask;
  assign resp_reg  = slots[rx.thread].wb_reg;

  // Byte and halfword loads land in the low bits, zero extended
  always_comb
  begin
    case (resp_mask)
      4'b0001: resp_data = {24'd0, rx.data[7:0]};
      4'b0010: resp_data = {24'd0, rx.data[15:8]};
      4'b0100: resp_data = {24'd0, rx.data[23:16]};
      4'b1000: resp_data = {24'd0, rx.data[31:24]};
      4'b0011: resp_data = {16'd0, rx.data[15:0]};
      4'b1100: resp_data = {16'd0, rx.data[31:16]};
      default: resp_data = rx.data;
    endcase
  end

  // Stores complete silently, only loads write back
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      load_valid <= 1'b0;
    end
    else
    begin
      load_valid <= (|ack) && !rx.wr;
    end
  end

  always_ff @(posedge CLK)
  begin
    load.slice <= rx.thread;
    load.sel   <= resp_reg;
    load.data  <= resp_data;
  end

endmodule

/* raccoon_lsu.sv */
`include "raccoon_defines.svh"

module raccoon_lsu
#(
  parameter logic [`RACCOON_NODE_W-1:0] NODE_ID = `RACCOON_NODE_DEFAULT
)
(
  input  logic                        CLK,
  input  logic                        RST,

  input  raccoon_pkg::thread_id_t     slice,
  input  logic                        req_valid,
  input  raccoon_pkg::lsu_req_t       req,
  output logic [`RACCOON_THREADS-1:0] stall,

  output logic                        load_valid,
  output raccoon_pkg::load_result_t   load,

  input  raccoon_pkg::racc_pkt_t      ring_in,
  output raccoon_pkg::racc_pkt_t      ring_out
);

  import raccoon_pkg::*;

  logic [`RACCOON_THREADS-1:0] pending;
  logic [`RACCOON_THREADS-1:0] ack;
  thread_slot_t                slots [`RACCOON_THREADS];
  racc_pkt_t                   rx;

  // A thread is held in the pipeline for as long as it has a transaction out
  assign stall = pending;

  raccoon_req_decode req_decode_inst (
    .CLK       (CLK),
    .RST       (RST),
    .slice     (slice),
    .req_valid (req_valid),
    .req       (req),
    .ack       (ack),
    .pending   (pending),
    .slots     (slots)
  );

  // Retry only matters inside execute, where it clears the sent bit
  raccoon_bus_execute #(
    .NODE_ID (NODE_ID)
  ) bus_execute_inst (
    .CLK      (CLK),
    .RST      (RST),
    .ring_in  (ring_in),
    .ring_out (ring_out),
    .pending  (pending),
    .slots    (slots),
    .rx       (rx),
    .ack      (ack),
    .retry    ()
  );

  raccoon_load_result load_result_inst (
    .CLK        (CLK),
    .RST        (RST),
    .rx         (rx),
    .ack        (ack),
    .slots      (slots),
    .load_valid (load_valid),
    .load       (load)
  );

endmodule

/* tb_clock.sv */
module tb_clock
#(
  parameter int PERIOD_NS = 100
)
(
  output logic CLK
);

  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    CLK = 1'b0;
  end

  always #(PERIOD_NS / 2) CLK = ~CLK;

endmodule

/* tb_raccoon_lsu.sv */
`include "raccoon_defines.svh"

module tb_raccoon_lsu;

  timeunit 1ns;
  timeprecision 100ps;

  import raccoon_pkg::*;

  localparam int N_TXN = 200;
  localparam int WATCHDOG_CYCLES = N_TXN * 40;
  localparam logic [`RACCOON_NODE_W-1:0] NODE_ID = 6'd9;
  localparam int ID_RESET = 0;
  localparam int ID_STALL = 1;
  localparam int ID_REQ = 2;
  localparam int ID_LOAD = 3;
  localparam int ID_RETRY = 4;
  localparam int ID_FWD = 5;

  typedef logic [78:0] val_t;
  typedef enum int {IDLE, WAITING, ON_RING, ACKED} thr_state_t;
  typedef struct {
    int         due;
    logic [2:0] sel;
    logic [31:0] data;
  } exp_load_t;
  typedef struct {
    int        due;
    racc_pkt_t pkt;
  } fwd_t;

  logic                        CLK;
  logic                        RST;
  thread_id_t                  slice;
  logic                        req_valid;
  lsu_req_t                    req;
  racc_pkt_t                   ring_in;
  logic [`RACCOON_THREADS-1:0] stall;
  logic                        load_valid;
  load_result_t                load;
  racc_pkt_t                   ring_out;

  integer      seed;
  int          cycle;
  int          issued;
  int          completed;
  int          retries;
  int          forwards;
  thr_state_t  state [`RACCOON_THREADS];
  int          due [`RACCOON_THREADS];
  int          clr_at [`RACCOON_THREADS];
  bit          retried [`RACCOON_THREADS];
  lsu_req_t    exp_req [`RACCOON_THREADS];
  exp_load_t   exp_q [`RACCOON_THREADS][$];
  fwd_t        fwd_q [$];
  logic [31:0] mem [16];
  string       test_name [6] = '{"reset", "stall_rule", "request_packets",
                                 "load_format", "retry", "forwarding"};
  int          checks [6];
  int          errs [6];

  tb_clock #(.PERIOD_NS(100)) clock_inst (.CLK(CLK));

  raccoon_lsu #(.NODE_ID(NODE_ID)) raccoon_lsu_inst (
    .CLK        (CLK),
    .RST        (RST),
    .slice      (slice),
    .req_valid  (req_valid),
    .req        (req),
    .stall      (stall),
    .load_valid (load_valid),
    .load       (load),
    .ring_in    (ring_in),
    .ring_out   (ring_out)
  );

  task automatic check_eq(int id, val_t expected, val_t actual);
    checks[id]++;
    assert (expected === actual)
    else
    begin
      $display("CHECK FAILED %s: expected %h, actual %h at cycle %0d",
               test_name[id], expected, actual, cycle);
      errs[id]++;
    end
  endtask

  task automatic check_true(int id, bit cond, string what);
    checks[id]++;
    assert (cond)
    else
    begin
      $display("ERROR %s: %s at cycle %0d", test_name[id], what, cycle);
      errs[id]++;
    end
  endtask

  // Byte loads take the enabled lane, halfword loads the enabled half
  function automatic logic [31:0] format_load(logic [31:0] word, logic [3:0] mask);
    logic [31:0] f;
    f = word;
    if ($countones(mask) == 1)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (mask[b])
        begin
          f = {24'd0, word[8*b +: 8]};
        end
      end
    end
    else if (mask == 4'b0011)
    begin
      f = {16'd0, word[15:0]};
    end
    else if (mask == 4'b1100)
    begin
      f = {16'd0, word[31:16]};
    end
    return f;
  endfunction

  // The ring model picks up an owned request and schedules its response
  task automatic check_request(racc_pkt_t pkt);
    int          t;
    int          id;
    logic [31:0] r;
    t = int'(pkt.thread);
    id = retried[t] ? ID_RETRY : ID_REQ;
    check_true(ID_REQ, state[t] == WAITING, "request packet for a thread with nothing to send");
    check_eq(id, val_t'(exp_req[t].wr), val_t'(pkt.wr));
    check_eq(id, val_t'(1'b0), val_t'(pkt.ack));
    check_eq(id, val_t'(exp_req[t].mask), val_t'(pkt.mask));
    check_eq(id, val_t'(exp_req[t].wdata), val_t'(pkt.data));
    check_eq(id, val_t'(exp_req[t].addr), val_t'(pkt.addr));
    if (state[t] == WAITING)
    begin
      r = $random(seed);
      state[t] = ON_RING;
      due[t] = cycle + 1 + int'(r[1:0]);
    end
  endtask

  task automatic check_outputs();
    logic [`RACCOON_THREADS-1:0] exp_stall;
    bit                          lv_due;
    int                          lv_thr;
    exp_load_t                   el;
    fwd_t                        fw;
    lv_due = 1'b0;
    lv_thr = 0;
    for (int i = 0; i < `RACCOON_THREADS; i++)
    begin
      if (state[i] == ACKED && clr_at[i] == cycle)
      begin
        state[i] = IDLE;
      end
      exp_stall[i] = (state[i] != IDLE);
      if (exp_q[i].size() > 0 && exp_q[i][0].due == cycle)
      begin
        lv_due = 1'b1;
        lv_thr = i;
      end
    end
    check_eq(ID_STALL, val_t'(exp_stall), val_t'(stall));

    check_eq(ID_LOAD, val_t'(lv_due), val_t'(load_valid));
    if (lv_due)
    begin
      el = exp_q[lv_thr].pop_front();
      if (load_valid)
      begin
        check_eq(ID_LOAD, val_t'(thread_id_t'(lv_thr)), val_t'(load.slice));
        check_eq(ID_LOAD, val_t'(el.sel), val_t'(load.sel));
        check_eq(ID_LOAD, val_t'(el.data), val_t'(load.data));
      end
    end

    if (ring_out.valid && ring_out.node == NODE_ID)
    begin
      check_request(ring_out);
    end
    if (fwd_q.size() > 0 && fwd_q[0].due == cycle)
    begin
      fw = fwd_q.pop_front();
      check_eq(ID_FWD, val_t'(fw.pkt), val_t'(ring_out));
    end
    else if (ring_out.valid)
    begin
      check_true(ID_FWD, ring_out.node == NODE_ID, "foreign packet on ring_out out of turn");
    end
  endtask

  // One packet per cycle goes onto ring_in and a due response wins over foreign traffic
  task automatic drive_ring();
    racc_pkt_t   pkt;
    logic [31:0] r;
    logic [95:0] wide;
    exp_load_t   el;
    int          t;
    int          idx;
    t = -1;
    pkt = '0;
    for (int i = `RACCOON_THREADS - 1; i >= 0; i--)
    begin
      if (state[i] == ON_RING && due[i] <= cycle)
      begin
        t = i;
      end
    end
    if (t >= 0)
    begin
      r = $random(seed);
      idx = int'(exp_req[t].addr[5:2]);
      pkt.valid = 1'b1;
      pkt.wr = exp_req[t].wr;
      pkt.ack = (r[1:0] != 2'b00);
      pkt.node = NODE_ID;
      pkt.thread = thread_id_t'(t);
      pkt.mask = exp_req[t].mask;
      pkt.data = exp_req[t].wr ? exp_req[t].wdata : mem[idx];
      pkt.addr = exp_req[t].addr;
      if (!pkt.ack)
      begin
        state[t] = WAITING;
        retries++;
        retried[t] = 1'b1;
      end
      else
      begin
        state[t] = ACKED;
        clr_at[t] = cycle + 2;
        completed++;
        retried[t] = 1'b0;
        if (exp_req[t].wr)
        begin
          for (int b = 0; b < 4; b++)
          begin
            if (exp_req[t].mask[b])
            begin
              mem[idx][8*b +: 8] = exp_req[t].wdata[8*b +: 8];
            end
          end
        end
        else
        begin
          el.due = cycle + 2;
          el.sel = exp_req[t].wb_reg;
          el.data = format_load(mem[idx], exp_req[t].mask);
          exp_q[t].push_back(el);
        end
      end
    end
    else if (issued < N_TXN)
    begin
      r = $random(seed);
      if (r[1:0] == 2'b00)
      begin
        wide = {$random(seed), $random(seed), $random(seed)};
        pkt = wide[78:0];
        pkt.valid = 1'b1;
        if (pkt.node == NODE_ID)
        begin
          pkt.node = NODE_ID + 6'd1;
        end
        fwd_q.push_back('{due: cycle + 2, pkt: pkt});
        forwards++;
      end
    end
    ring_in = pkt;
  endtask

  // The pipeline only issues for a thread that the model sees as idle
  task automatic drive_request();
    logic [31:0] r;
    thread_id_t  s;
    int          t;
    r = $random(seed);
    s = r[1:0];
    t = (int'(s) + 2) % `RACCOON_THREADS;
    slice = s;
    req_valid = 1'b0;
    if (issued < N_TXN && r[2] && state[t] == IDLE)
    begin
      req_valid = 1'b1;
      req.wr = r[3];
      req.mask = r[7:4];
      req.wb_reg = r[10:8];
      req.addr = {26'd0, r[14:11], 2'b00};
      req.wdata = $random(seed);
      exp_req[t] = req;
      state[t] = WAITING;
      issued++;
    end
  endtask

  function automatic bit traffic_done();
    bit done;
    done = (completed == N_TXN) && (fwd_q.size() == 0);
    for (int i = 0; i < `RACCOON_THREADS; i++)
    begin
      done = done && (state[i] == IDLE) && (exp_q[i].size() == 0);
    end
    return done;
  endfunction

  task automatic report_test(int id);
    $display("test %-16s %0d checks, %0d errors", test_name[id], checks[id], errs[id]);
  endtask

  initial
  begin
    int total_checks;
    int total_errs;
    seed = 32'hf862aee2;
    RST = 1'b1;
    slice = '0;
    req_valid = 1'b0;
    req = '0;
    ring_in = '0;
    cycle = 0;
    issued = 0;
    completed = 0;
    retries = 0;
    forwards = 0;
    for (int i = 0; i < 16; i++)
    begin
      mem[i] = 32'hc3a50000 ^ (32'(i) * 32'h01030507);
    end
    for (int i = 0; i < `RACCOON_THREADS; i++)
    begin
      state[i] = IDLE;
      retried[i] = 1'b0;
    end

    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    check_eq(ID_RESET, val_t'(4'b0000), val_t'(stall));
    check_eq(ID_RESET, val_t'(1'b0), val_t'(load_valid));
    check_eq(ID_RESET, val_t'(1'b0), val_t'(ring_out.valid));
    report_test(ID_RESET);

    while (!traffic_done())
    begin
      @(negedge CLK);
      cycle++;
      check_outputs();
      drive_ring();
      drive_request();
    end

    check_true(ID_RETRY, retries > 0, "no retry response was ever generated");
    check_true(ID_FWD, forwards > 0, "no foreign packet was ever injected");
    for (int id = ID_STALL; id <= ID_FWD; id++)
    begin
      report_test(id);
    end

    total_checks = 0;
    total_errs = 0;
    for (int id = 0; id < 6; id++)
    begin
      total_checks += checks[id];
      total_errs += errs[id];
    end
    $display("Summary: %0d checks, %0d errors, %0d transactions, %0d retries, %0d forwarded",
             total_checks, total_errs, completed, retries, forwards);
    if (total_errs == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Forty cycles per transaction is far more than any healthy run needs
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, the traffic never drained", WATCHDOG_CYCLES);
    $display("Finished with errors");
    $finish;
  end

endmodule

/* sources.f */
+incdir+.
raccoon_pkg.sv
raccoon_req_decode.sv
raccoon_bus_execute.sv
raccoon_load_result.sv
raccoon_lsu.sv
tb_clock.sv
tb_raccoon_lsu.sv

/* run.sh */
#!/bin/sh
# Build and run the LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_raccoon_lsu -f sources.f \
  --Mdir obj_dir -o tb_raccoon_lsu

./obj_dir/tb_raccoon_lsu 2>&1 | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
  exit 0
else
  exit 1
fi
